// ==== tb.f ====
+incdir+hdl
hdl/spr_pkg.sv
hdl/spr_oam.sv
hdl/spr_eval.sv
hdl/spr_fetch.sv
hdl/spr_shifter_bank.sv
hdl/ppu_sprite.sv
sim/ppu_sprite_properties.sv
sim/tb_ppu_sprite.sv

// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_ppu_sprite
FILELIST = tb.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_ppu_sprite.sv ====
`include "spr_consts.svh"

module tb_ppu_sprite;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_ROWS = 23;
	localparam int WATCH_LINES = NUM_ROWS * 3 + 4; // Each row costs under three lines of cycles

	typedef struct packed {
		logic [3:0] setup;
		spr_pkg::coord_t line; // Line where the pixel is probed
		spr_pkg::coord_t x;
		logic ren;
		logic lcol;
		spr_pkg::spr_pixel_t exp_pix;
		logic exp_spr0;
		logic exp_ovf;
	} row_t;

	logic clk;
	logic rst_n;
	logic spr_render_en;
	spr_pkg::coord_t x_pos;
	spr_pkg::coord_t y_pos;
	logic cpu_oam_req;
	logic cpu_oam_rw;
	spr_pkg::byte_t spr_addr_in;
	spr_pkg::byte_t spr_data_in;
	spr_pkg::byte_t vram_data_in;
	logic spr_pt_sel;
	logic show_spr_left_col;
	logic spr_overflow;
	logic spr_pri_out;
	logic [3:0] spr_pal_sel;
	spr_pkg::byte_t spr_data_out;
	spr_pkg::vram_addr_t vram_addr_out;
	logic spr_vram_req;
	logic spr_0_rendering;

	spr_pkg::oam_entry_t shadow [`SPR_NUM_OAM];
	spr_pkg::byte_t cpu_mem [256];
	row_t rows [NUM_ROWS];
	logic [31:0] lcg_state = 32'h7b56_7b00;

	ppu_sprite ppu_sprite_inst (.*);

	function automatic spr_pkg::byte_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	// Pattern memory contents put the row in the top bits so vertical flip shows
	function automatic spr_pkg::byte_t vram_byte(spr_pkg::byte_t tile, logic plane, logic [2:0] r);
		spr_pkg::byte_t lo;
		lo = tile ^ {r, 5'b00000};
		return plane ? (lo ^ 8'h0F) : lo;
	endfunction

	function automatic spr_pkg::byte_t reverse_byte(spr_pkg::byte_t b);
		spr_pkg::byte_t r;
		for (int i = 0; i < 8; i++) begin
			r[i] = b[7 - i];
		end
		return r;
	endfunction

	function automatic spr_pkg::oam_entry_t make_entry(int y, int tile, int attr, int x);
		return {8'(x), 8'(attr), 8'(tile), 8'(y)};
	endfunction

	function automatic row_t make_row(int setup, int line, int x, logic ren, logic lcol);
		row_t r;
		r = '0;
		r.setup = 4'(setup);
		r.line = spr_pkg::coord_t'(line);
		r.x = spr_pkg::coord_t'(x);
		r.ren = ren;
		r.lcol = lcol;
		return r;
	endfunction

	// Reference model that evaluates the line above and finds the winning slot at the probe x
	task automatic compute_expected(inout row_t r);
		int ev;
		int k;
		int sx;
		int found;
		int bitn;
		logic [2:0] rown;
		logic hit;
		logic [1:0] col;
		spr_pkg::byte_t lo;
		spr_pkg::byte_t hi;
		ev = int'(r.line) - 1;
		k = int'(r.x);
		found = 0;
		hit = 1'b0;
		r.exp_pix = '{behind: 1'b1, pal_sel: 4'h0};
		r.exp_spr0 = 1'b0;
		r.exp_ovf = 1'b0;
		for (int i = 0; i < `SPR_NUM_OAM; i++) begin
			if (ev >= int'(shadow[i].y) && ev < int'(shadow[i].y) + `SPR_HEIGHT) begin
				if (found == `SPR_NUM_SLOTS) begin
					r.exp_ovf = 1'b1;
					break;
				end
				sx = int'(shadow[i].x);
				if (k >= sx + 1 && k <= sx + 8) begin
					if (i == 0) r.exp_spr0 = 1'b1;
					rown = 3'(ev - int'(shadow[i].y));
					if (shadow[i].attr.vflip) rown = ~rown;
					lo = vram_byte(shadow[i].tile, 1'b0, rown);
					hi = vram_byte(shadow[i].tile, 1'b1, rown);
					if (shadow[i].attr.hflip) begin
						lo = reverse_byte(lo);
						hi = reverse_byte(hi);
					end
					bitn = 7 - (k - sx - 1); // Leftmost pixel is bit 7
					col = {hi[bitn], lo[bitn]};
					if (!hit && col != 2'b00) begin
						hit = 1'b1;
						r.exp_pix = '{behind: shadow[i].attr.behind,
							pal_sel: {shadow[i].attr.palette, col}};
					end
				end
				found++;
			end
		end
		if (k < 1 || k > 256 || r.line < 1 || r.line > 239) r.exp_spr0 = 1'b0;
		if (!r.ren || k < 1 || k > 256 || r.line < 1 || r.line > 239 || (!r.lcol && k < 9))
			r.exp_pix = '{behind: 1'b1, pal_sel: 4'h0};
	endtask

	task automatic report_fail(string name, logic [31:0] got, logic [31:0] exp);
		$display("FAIL %s got %h expected %h", name, got, exp);
		$display("TB FAILED");
		$fatal(1, "Value mismatch on %s", name);
	endtask

	task automatic check_pixel(string name, spr_pkg::spr_pixel_t got, spr_pkg::spr_pixel_t exp);
		if (got !== exp) report_fail(name, 32'(got), 32'(exp));
	endtask

	task automatic check_byte(string name, spr_pkg::byte_t got, spr_pkg::byte_t exp);
		if (got !== exp) report_fail(name, 32'(got), 32'(exp));
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) report_fail(name, 32'(got), 32'(exp));
	endtask

	task automatic cpu_access(logic rw, spr_pkg::byte_t addr, spr_pkg::byte_t data);
		@(posedge clk);
		#10;
		x_pos = 9'd300; // Outside the OAM ownership window
		y_pos = 9'd240;
		spr_render_en = 1'b0;
		cpu_oam_req = 1'b1;
		cpu_oam_rw = rw;
		spr_addr_in = addr;
		spr_data_in = data;
	endtask

	task automatic cpu_idle();
		@(posedge clk);
		#10;
		cpu_oam_req = 1'b0;
	endtask

	task automatic load_setup(int id);
		for (int i = 0; i < `SPR_NUM_OAM; i++) begin
			shadow[i] = make_entry(240, lcg_next(), lcg_next(), lcg_next()); // Off every line
		end
		case (id)
			0: shadow[0] = make_entry(20, 8'h5A, 8'h02, 40);
			1: shadow[0] = make_entry(20, 8'h5A, 8'h41, 40);
			2: shadow[0] = make_entry(20, 8'h5A, 8'h82, 40);
			3: shadow[0] = make_entry(20, 8'h5A, 8'hE3, 40);
			4: begin
				shadow[0] = make_entry(60, 8'h0F, 8'h01, 50);
				shadow[1] = make_entry(60, 8'hF0, 8'h22, 53);
			end
			5: shadow[0] = make_entry(30, 8'hF0, 8'h03, 2);
			6: begin
				for (int i = 0; i < 9; i++) begin
					shadow[i] = make_entry(100, 8'hF0, i % 4, i * 24);
				end
			end
			default: shadow[5] = make_entry(80, 8'h3C, 8'h01, 100);
		endcase
		for (int a = 0; a < 256; a++) begin
			cpu_access(1'b0, 8'(a), shadow[a / 4][(a % 4) * 8 +: 8]);
		end
		cpu_idle();
	endtask

	// Timing generator for one whole line that samples mid-cycle
	task automatic run_line(input spr_pkg::coord_t y, input logic ren, input int probe_x,
		output logic ovf_seen, output spr_pkg::spr_pixel_t pix, output logic spr0);
		ovf_seen = 1'b0;
		pix = '0;
		spr0 = 1'b0;
		for (int x = 0; x <= 340; x++) begin
			@(posedge clk);
			#10;
			x_pos = spr_pkg::coord_t'(x);
			y_pos = y;
			spr_render_en = ren;
			#40;
			if (spr_overflow) ovf_seen = 1'b1;
			if (x == probe_x) begin
				pix = {spr_pri_out, spr_pal_sel};
				spr0 = spr_0_rendering;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Pattern memory answers in the cycle after the address
	always begin
		spr_pkg::vram_addr_t a;
		logic req;
		@(negedge clk);
		a = vram_addr_out;
		req = spr_vram_req;
		if (req) begin
			check_flag("vram_addr_out[12]", a[12], spr_pt_sel);
		end else begin
			check_flag("vram_addr_out idle", |a, 1'b0);
		end
		@(posedge clk);
		#10;
		vram_data_in = req ? vram_byte(a[11:4], a[3], a[2:0]) : 8'h00;
	end

	initial begin
		#(WATCH_LINES * 341 * 2 * 100);
		$display("Timeout: the run did not finish in the expected number of lines");
		$display("TB FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		logic ovf;
		logic spr0;
		spr_pkg::spr_pixel_t pix;
		spr_pkg::byte_t d;
		rst_n = 1'b1;
		spr_render_en = 1'b0;
		x_pos = '0;
		y_pos = '0;
		cpu_oam_req = 1'b0;
		cpu_oam_rw = 1'b0;
		spr_addr_in = '0;
		spr_data_in = '0;
		vram_data_in = '0;
		spr_pt_sel = 1'b1;
		show_spr_left_col = 1'b1;
		#5 rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#10 rst_n = 1'b1;

		rows[0] = make_row(0, 21, 41, 1, 1);
		rows[1] = make_row(0, 21, 44, 1, 1);
		rows[2] = make_row(0, 26, 48, 1, 1);
		rows[3] = make_row(0, 21, 49, 1, 1);
		rows[4] = make_row(0, 21, 40, 1, 1);
		rows[5] = make_row(1, 21, 41, 1, 1);
		rows[6] = make_row(1, 25, 46, 1, 1);
		rows[7] = make_row(2, 21, 42, 1, 1);
		rows[8] = make_row(2, 27, 47, 1, 1);
		rows[9] = make_row(3, 22, 41, 1, 1);
		rows[10] = make_row(3, 28, 45, 1, 1);
		rows[11] = make_row(4, 61, 54, 1, 1); // Lower slot transparent here
		rows[12] = make_row(4, 61, 56, 1, 1);
		rows[13] = make_row(4, 61, 60, 1, 1);
		rows[14] = make_row(5, 31, 4, 1, 0);
		rows[15] = make_row(5, 31, 4, 1, 1);
		rows[16] = make_row(5, 31, 9, 1, 0);
		rows[17] = make_row(0, 21, 44, 0, 1);
		rows[18] = make_row(6, 101, 3, 1, 1);
		rows[19] = make_row(6, 101, 170, 1, 1);
		rows[20] = make_row(6, 101, 195, 1, 1); // Ninth sprite must stay hidden
		rows[21] = make_row(6, 101, 100, 1, 1);
		rows[22] = make_row(7, 81, 103, 1, 1);

		for (int a = 0; a < 256; a++) begin
			d = lcg_next();
			cpu_mem[a] = d;
			cpu_access(1'b0, 8'(a), d);
		end
		for (int a = 0; a < 256; a++) begin
			cpu_access(1'b1, 8'(a), 8'h00);
			cpu_idle();
			#40;
			check_byte($sformatf("spr_data_out[%0d]", a), spr_data_out, cpu_mem[a]);
		end

		for (int n = 0; n < NUM_ROWS; n++) begin
			load_setup(int'(rows[n].setup));
			compute_expected(rows[n]);
			show_spr_left_col = rows[n].lcol;
			spr_pt_sel = n[0]; // Both pattern tables get used
			run_line(rows[n].line - 1'b1, 1'b1, -1, ovf, pix, spr0);
			check_flag($sformatf("spr_overflow row %0d", n), ovf, rows[n].exp_ovf);
			run_line(rows[n].line, rows[n].ren, int'(rows[n].x), ovf, pix, spr0);
			check_pixel($sformatf("pixel row %0d", n), pix, rows[n].exp_pix);
			check_flag($sformatf("spr_0_rendering row %0d", n), spr0, rows[n].exp_spr0);
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== sim/ppu_sprite_properties.sv ====
module ppu_sprite_properties (
	input logic clk,
	input logic rst_n,
	input spr_pkg::coord_t x_pos,
	input logic spr_vram_req,
	input spr_pkg::vram_addr_t vram_addr_out,
	input logic spr_overflow,
	input logic spr_0_rendering,
	input logic spr_pri_out,
	input logic [3:0] spr_pal_sel
);
	timeunit 1ns;
	timeprecision 100ps;

	// Pattern fetches belong to horizontal blank
	vram_req_window: assert property (@(posedge clk) disable iff (!rst_n)
		spr_vram_req |-> (x_pos >= 9'd256 && x_pos <= 9'd295))
		else $error("VRAM request outside the fetch window");

	// The high plane follows its low plane two cycles later with the same tile and row
	addr_planes: assert property (@(posedge clk) disable iff (!rst_n)
		(spr_vram_req && vram_addr_out[3]) |-> (!vram_addr_out[13]
		&& $past(spr_vram_req, 2) && !$past(vram_addr_out[3], 2)
		&& vram_addr_out[12:4] == $past(vram_addr_out[12:4], 2)
		&& vram_addr_out[2:0] == $past(vram_addr_out[2:0], 2)))
		else $error("VRAM high plane request without its matching low plane");

	overflow_window: assert property (@(posedge clk) disable iff (!rst_n)
		spr_overflow |-> (x_pos >= 9'd64 && x_pos <= 9'd193))
		else $error("Overflow pulse outside the evaluation window");

	reset_outputs: assert property (@(posedge clk) !rst_n |->
		(!spr_vram_req && !spr_overflow && !spr_0_rendering && spr_pri_out && spr_pal_sel == 4'h0))
		else $error("Outputs active during reset");

endmodule

bind ppu_sprite ppu_sprite_properties props_inst (
	.clk(clk), .rst_n(rst_n), .x_pos(x_pos), .spr_vram_req(spr_vram_req),
	.vram_addr_out(vram_addr_out), .spr_overflow(spr_overflow),
	.spr_0_rendering(spr_0_rendering), .spr_pri_out(spr_pri_out), .spr_pal_sel(spr_pal_sel)
);

// ==== hdl/ppu_sprite.sv ====
module ppu_sprite (
	input logic clk,
	input logic rst_n,
	input logic spr_render_en,
	input spr_pkg::coord_t x_pos,
	input spr_pkg::coord_t y_pos,
	input logic cpu_oam_req,
	input logic cpu_oam_rw,
	input spr_pkg::byte_t spr_addr_in,
	input spr_pkg::byte_t spr_data_in,
	input spr_pkg::byte_t vram_data_in,
	input logic spr_pt_sel, // Pattern table at $0000 or $1000
	input logic show_spr_left_col,
	output logic spr_overflow,
	output logic spr_pri_out,
	output logic [3:0] spr_pal_sel,
	output spr_pkg::byte_t spr_data_out,
	output spr_pkg::vram_addr_t vram_addr_out,
	output logic spr_vram_req,
	output logic spr_0_rendering
);

	spr_pkg::cpu_oam_req_t cpu;
	spr_pkg::oam_idx_t oam_rd_idx;
	spr_pkg::oam_entry_t oam_entry;
	spr_pkg::slot_idx_t slot_idx;
	spr_pkg::oam_entry_t slot_entry;
	spr_pkg::slot_cnt_t sprite_count;
	spr_pkg::spr_load_t load;
	spr_pkg::spr_pixel_t pixel;
	logic render_owns;
	logic oam_rd_en;
	logic spr0_in_slot0;

	assign cpu = '{req: cpu_oam_req, rw: cpu_oam_rw, addr: spr_addr_in, wdata: spr_data_in};
	assign {spr_pri_out, spr_pal_sel} = pixel;

	spr_oam oam_inst (
		.clk(clk), .rst_n(rst_n), .cpu(cpu), .render_owns(render_owns),
		.rd_en(oam_rd_en), .rd_idx(oam_rd_idx), .rd_entry(oam_entry),
		.cpu_rdata(spr_data_out)
	);

	spr_eval eval_inst (
		.clk(clk), .rst_n(rst_n), .x_pos(x_pos), .y_pos(y_pos),
		.spr_render_en(spr_render_en), .oam_rd_en(oam_rd_en), .oam_rd_idx(oam_rd_idx),
		.oam_entry(oam_entry), .render_owns(render_owns), .slot_idx(slot_idx),
		.slot_entry(slot_entry), .sprite_count(sprite_count),
		.spr0_in_slot0(spr0_in_slot0), .spr_overflow(spr_overflow)
	);

	spr_fetch fetch_inst (
		.clk(clk), .rst_n(rst_n), .x_pos(x_pos), .y_pos(y_pos),
		.spr_render_en(spr_render_en), .spr_pt_sel(spr_pt_sel), .slot_idx(slot_idx),
		.slot_entry(slot_entry), .sprite_count(sprite_count), .spr0_in_slot0(spr0_in_slot0),
		.vram_data_in(vram_data_in), .vram_addr_out(vram_addr_out),
		.spr_vram_req(spr_vram_req), .load(load)
	);

	spr_shifter_bank shifter_inst (
		.clk(clk), .rst_n(rst_n), .x_pos(x_pos), .y_pos(y_pos),
		.spr_render_en(spr_render_en), .show_spr_left_col(show_spr_left_col),
		.load(load), .pixel(pixel), .spr_0_rendering(spr_0_rendering)
	);

endmodule

// ==== hdl/spr_shifter_bank.sv ====
`include "spr_consts.svh"

module spr_shifter_bank (
	input logic clk,
	input logic rst_n,
	input spr_pkg::coord_t x_pos,
	input spr_pkg::coord_t y_pos,
	input logic spr_render_en,
	input logic show_spr_left_col,
	input spr_pkg::spr_load_t load,
	output spr_pkg::spr_pixel_t pixel,
	output logic spr_0_rendering
);

	spr_pkg::byte_t pt_lo [`SPR_NUM_SLOTS];
	spr_pkg::byte_t pt_hi [`SPR_NUM_SLOTS];
	spr_pkg::spr_attr_t attr [`SPR_NUM_SLOTS];
	spr_pkg::coord_t cnt [`SPR_NUM_SLOTS];
	logic [`SPR_NUM_SLOTS-1:0] active;
	logic spr0_q;
	logic active_pixel;
	logic masked;

	assign active_pixel = (x_pos != '0) && (x_pos <= `SPR_ACTIVE_X_MAX)
		&& (y_pos != '0) && (y_pos <= `SPR_ACTIVE_Y_MAX);
	assign masked = !spr_render_en || !active_pixel
		|| (!show_spr_left_col && x_pos < `SPR_LEFT_MASK_X);

	// A slot draws while its counter sits in the window 0 down to -7
	always_comb begin
		for (int i = 0; i < `SPR_NUM_SLOTS; i++) begin
			active[i] = spr_pkg::coord_t'(cnt[i] + (`SPR_HEIGHT - 1))
				< spr_pkg::coord_t'(`SPR_HEIGHT);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `SPR_NUM_SLOTS; i++) begin
				cnt[i] <= 9'h100; // Parked well outside the draw window
			end
			spr0_q <= 1'b0;
		end else if (load.load) begin
			cnt[load.slot] <= {1'b0, load.x};
			if (load.slot == '0) begin
				spr0_q <= load.spr0;
			end
		end else if (active_pixel) begin
			for (int i = 0; i < `SPR_NUM_SLOTS; i++) begin
				cnt[i] <= cnt[i] - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load.load) begin
			pt_lo[load.slot] <= load.pt_low;
			pt_hi[load.slot] <= load.pt_high;
			attr[load.slot] <= load.attr;
		end else if (active_pixel) begin
			for (int i = 0; i < `SPR_NUM_SLOTS; i++) begin
				if (active[i]) begin
					pt_lo[i] <= {pt_lo[i][6:0], 1'b0}; // Leftmost pixel leaves first
					pt_hi[i] <= {pt_hi[i][6:0], 1'b0};
				end
			end
		end
	end

	// Walk from the highest slot down so the lowest opaque slot wins
	always_comb begin
		pixel = '{behind: 1'b1, pal_sel: 4'h0};
		for (int i = `SPR_NUM_SLOTS - 1; i >= 0; i--) begin
			if (active[i] && {pt_hi[i][7], pt_lo[i][7]} != 2'b00) begin
				pixel.behind = attr[i].behind;
				pixel.pal_sel = {attr[i].palette, pt_hi[i][7], pt_lo[i][7]};
			end
		end
		if (masked) begin
			pixel = '{behind: 1'b1, pal_sel: 4'h0};
		end
	end

	assign spr_0_rendering = spr0_q && active[0] && active_pixel;

endmodule

// ==== hdl/spr_fetch.sv ====
`include "spr_consts.svh"

module spr_fetch (
	input logic clk,
	input logic rst_n,
	input spr_pkg::coord_t x_pos,
	input spr_pkg::coord_t y_pos,
	input logic spr_render_en,
	input logic spr_pt_sel,
	output spr_pkg::slot_idx_t slot_idx,
	input spr_pkg::oam_entry_t slot_entry,
	input spr_pkg::slot_cnt_t sprite_count,
	input logic spr0_in_slot0,
	input spr_pkg::byte_t vram_data_in,
	output spr_pkg::vram_addr_t vram_addr_out,
	output logic spr_vram_req,
	output spr_pkg::spr_load_t load
);

	spr_pkg::fetch_state_t state;
	spr_pkg::slot_idx_t cur_slot;
	spr_pkg::oam_entry_t ent;
	spr_pkg::byte_t pt_low;
	spr_pkg::byte_t pt_high;
	logic [2:0] row_raw;
	logic [2:0] row;
	logic plane;
	logic line_ok;
	logic slot_used;

	// Mirrors a pattern byte when the sprite is flipped horizontally
	function automatic spr_pkg::byte_t flip_byte(input spr_pkg::byte_t b, input logic hflip);
		spr_pkg::byte_t r;
		for (int i = 0; i < 8; i++) begin
			r[i] = b[7 - i];
		end
		return hflip ? r : b;
	endfunction

	assign line_ok = spr_render_en && (y_pos < `SPR_LAST_EVAL_Y);
	assign slot_idx = cur_slot;
	assign slot_used = spr_pkg::slot_cnt_t'(cur_slot) < sprite_count; // Empty slots load zeros

	assign row_raw = y_pos[2:0] - ent.y[2:0];
	assign row = ent.attr.vflip ? ~row_raw : row_raw;
	assign plane = (state == spr_pkg::FETCH_HIGH_ADDR);
	assign spr_vram_req = (state == spr_pkg::FETCH_LOW_ADDR) || plane;
	assign vram_addr_out = spr_vram_req ? {1'b0, spr_pt_sel, ent.tile, plane, row} : '0;

	assign pt_high = slot_used ? flip_byte(vram_data_in, ent.attr.hflip) : '0;

	always_comb begin
		load = '0;
		load.load = (state == spr_pkg::FETCH_HIGH_DATA); // High byte goes straight to the shifter
		load.slot = cur_slot;
		load.attr = ent.attr;
		load.x = ent.x;
		load.pt_low = pt_low;
		load.pt_high = pt_high;
		load.spr0 = (cur_slot == '0) && spr0_in_slot0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= spr_pkg::FETCH_IDLE;
			cur_slot <= '0;
		end else begin
			case (state)
				spr_pkg::FETCH_IDLE: begin
					if (line_ok && x_pos == `SPR_FETCH_X) begin
						state <= spr_pkg::FETCH_ENTRY;
						cur_slot <= '0;
					end
				end
				spr_pkg::FETCH_ENTRY: state <= spr_pkg::FETCH_LOW_ADDR;
				spr_pkg::FETCH_LOW_ADDR: state <= spr_pkg::FETCH_LOW_DATA;
				spr_pkg::FETCH_LOW_DATA: state <= spr_pkg::FETCH_HIGH_ADDR;
				spr_pkg::FETCH_HIGH_ADDR: state <= spr_pkg::FETCH_HIGH_DATA;
				spr_pkg::FETCH_HIGH_DATA: begin
					if (cur_slot == spr_pkg::slot_idx_t'(`SPR_NUM_SLOTS - 1)) begin
						state <= spr_pkg::FETCH_IDLE;
					end else begin
						cur_slot <= cur_slot + 1'b1;
						state <= spr_pkg::FETCH_ENTRY;
					end
				end
				default: state <= spr_pkg::FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == spr_pkg::FETCH_ENTRY) begin
			ent <= slot_entry;
		end
		if (state == spr_pkg::FETCH_LOW_DATA) begin
			pt_low <= slot_used ? flip_byte(vram_data_in, ent.attr.hflip) : '0;
		end
	end

endmodule

// ==== hdl/spr_eval.sv ====
`include "spr_consts.svh"

module spr_eval (
	input logic clk,
	input logic rst_n,
	input spr_pkg::coord_t x_pos,
	input spr_pkg::coord_t y_pos,
	input logic spr_render_en,
	output logic oam_rd_en,
	output spr_pkg::oam_idx_t oam_rd_idx,
	input spr_pkg::oam_entry_t oam_entry,
	output logic render_owns,
	input spr_pkg::slot_idx_t slot_idx,
	output spr_pkg::oam_entry_t slot_entry,
	output spr_pkg::slot_cnt_t sprite_count,
	output logic spr0_in_slot0,
	output logic spr_overflow
);

	spr_pkg::eval_state_t state;
	spr_pkg::oam_idx_t cur_idx;
	spr_pkg::slot_idx_t clr_idx;
	spr_pkg::slot_cnt_t count;
	spr_pkg::oam_entry_t sec_oam [`SPR_NUM_SLOTS];
	spr_pkg::coord_t y_top;
	logic line_ok;
	logic in_range;
	logic full;

	assign line_ok = spr_render_en && (y_pos < `SPR_LAST_EVAL_Y);
	assign render_owns = spr_render_en && (x_pos != '0) && (x_pos <= `SPR_ACTIVE_X_MAX);

	// Range test uses the entry that OAM returned for the previous READ cycle
	assign y_top = {1'b0, oam_entry.y};
	assign in_range = (y_pos >= y_top) && (y_pos < y_top + spr_pkg::coord_t'(`SPR_HEIGHT));
	assign full = (count == spr_pkg::slot_cnt_t'(`SPR_NUM_SLOTS));

	assign oam_rd_en = (state == spr_pkg::EVAL_READ);
	assign oam_rd_idx = cur_idx;
	assign slot_entry = sec_oam[slot_idx]; // Combinational port for the fetch sequencer
	assign sprite_count = count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= spr_pkg::EVAL_IDLE;
			cur_idx <= '0;
			clr_idx <= '0;
			count <= '0;
			spr0_in_slot0 <= 1'b0;
			spr_overflow <= 1'b0;
		end else begin
			spr_overflow <= 1'b0;
			case (state)
				spr_pkg::EVAL_IDLE: begin
					if (line_ok && x_pos == '0) begin
						state <= spr_pkg::EVAL_CLEAR;
						clr_idx <= '0;
						count <= '0;
						spr0_in_slot0 <= 1'b0;
					end else if (line_ok && x_pos == `SPR_EVAL_X) begin
						state <= spr_pkg::EVAL_READ;
						cur_idx <= '0;
					end
				end
				spr_pkg::EVAL_CLEAR: begin
					clr_idx <= clr_idx + 1'b1;
					if (clr_idx == spr_pkg::slot_idx_t'(`SPR_NUM_SLOTS - 1)) begin
						state <= spr_pkg::EVAL_IDLE;
					end
				end
				spr_pkg::EVAL_READ: begin
					state <= spr_pkg::EVAL_CHECK;
				end
				spr_pkg::EVAL_CHECK: begin
					if (in_range && full) begin
						spr_overflow <= 1'b1; // Ninth sprite ends the search
						state <= spr_pkg::EVAL_IDLE;
					end else begin
						if (in_range) begin
							count <= count + 1'b1;
							if (cur_idx == '0) begin
								spr0_in_slot0 <= 1'b1; // Sprite 0 is always first to land
							end
						end
						if (cur_idx == spr_pkg::oam_idx_t'(`SPR_NUM_OAM - 1)) begin
							state <= spr_pkg::EVAL_IDLE;
						end else begin
							cur_idx <= cur_idx + 1'b1;
							state <= spr_pkg::EVAL_READ;
						end
					end
				end
				default: state <= spr_pkg::EVAL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == spr_pkg::EVAL_CLEAR) begin
			sec_oam[clr_idx] <= spr_pkg::oam_entry_t'({4{`SPR_EMPTY_BYTE}});
		end else if (state == spr_pkg::EVAL_CHECK && in_range && !full) begin
			sec_oam[count[2:0]] <= oam_entry;
		end
	end

endmodule

// ==== hdl/spr_oam.sv ====
`include "spr_consts.svh"

module spr_oam (
	input logic clk,
	input logic rst_n,
	input spr_pkg::cpu_oam_req_t cpu,
	input logic render_owns,
	input logic rd_en,
	input spr_pkg::oam_idx_t rd_idx,
	output spr_pkg::oam_entry_t rd_entry,
	output spr_pkg::byte_t cpu_rdata
);

	spr_pkg::oam_entry_t mem [`SPR_NUM_OAM];
	spr_pkg::oam_idx_t cpu_idx;
	logic [4:0] cpu_bit; // Bit offset of the addressed byte inside its entry
	logic cpu_rd;
	logic cpu_wr;

	assign cpu_idx = cpu.addr[7:2];
	assign cpu_bit = {cpu.addr[1:0], 3'b000};

	// The CPU is locked out while the renderer walks OAM
	assign cpu_rd = cpu.req && cpu.rw && !render_owns;
	assign cpu_wr = cpu.req && !cpu.rw && !render_owns;

	always_ff @(posedge clk) begin
		if (cpu_wr) begin
			mem[cpu_idx][cpu_bit +: 8] <= cpu.wdata; // Byte lane write
		end
		if (render_owns && rd_en) begin
			rd_entry <= mem[rd_idx]; // Whole entry for the evaluator
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cpu_rdata <= '0;
		end else if (cpu_rd) begin
			cpu_rdata <= mem[cpu_idx][cpu_bit +: 8];
		end
	end

endmodule

// ==== hdl/spr_pkg.sv ====
package spr_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [8:0] coord_t;
	typedef logic [13:0] vram_addr_t;
	typedef logic [5:0] oam_idx_t;
	typedef logic [2:0] slot_idx_t;
	typedef logic [3:0] slot_cnt_t; // Holds 0 to 8

	typedef struct packed {
		logic vflip;
		logic hflip;
		logic behind; // Sprite sits behind the background
		logic [2:0] unused;
		logic [1:0] palette;
	} spr_attr_t;

	// Field order matches the OAM byte order, Y in byte 0 and X in byte 3
	typedef struct packed {
		byte_t x;
		spr_attr_t attr;
		byte_t tile;
		byte_t y;
	} oam_entry_t;

	typedef struct packed {
		logic load;
		slot_idx_t slot;
		spr_attr_t attr;
		byte_t x;
		byte_t pt_low;
		byte_t pt_high;
		logic spr0; // Slot carries OAM sprite 0
	} spr_load_t;

	typedef struct packed {
		logic behind;
		logic [3:0] pal_sel;
	} spr_pixel_t;

	typedef struct packed {
		logic req;
		logic rw; // High for a read
		byte_t addr;
		byte_t wdata;
	} cpu_oam_req_t;

	typedef enum logic [1:0] {EVAL_IDLE, EVAL_CLEAR, EVAL_READ, EVAL_CHECK} eval_state_t;

	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_ENTRY,
		FETCH_LOW_ADDR,
		FETCH_LOW_DATA,
		FETCH_HIGH_ADDR,
		FETCH_HIGH_DATA
	} fetch_state_t;

endpackage

// ==== hdl/spr_consts.svh ====
`ifndef SPR_CONSTS_SVH
`define SPR_CONSTS_SVH

// Storage sizes
`define SPR_NUM_OAM       64  // Sprites held in primary OAM
`define SPR_NUM_SLOTS     8   // Sprites drawn on one scanline
`define SPR_HEIGHT        8   // Sprite height in lines

// Beam positions that start each phase of a line
`define SPR_EVAL_X        64  // First cycle of sprite evaluation
`define SPR_FETCH_X       256 // First cycle of the pattern fetch
`define SPR_LAST_EVAL_Y   239 // Evaluation runs on lines below this one

// Visible picture
`define SPR_ACTIVE_X_MAX  256 // Last active pixel of a line
`define SPR_ACTIVE_Y_MAX  239 // Last active line of a frame
`define SPR_LEFT_MASK_X   9   // Pixels left of this are hidden by the column mask

`define SPR_EMPTY_BYTE    8'hFF // Fill value of an unused secondary OAM slot

`endif
